/* noc_pkg.sv */
package noc_pkg;

	// Width of one mesh coordinate in a header
	parameter int ADDR_FIELD = 4;

	// Router ports, listed in request-vector order
	typedef enum logic [2:0]
	{
		PE    = 3'd0,
		X_POS = 3'd1,
		Y_POS = 3'd2,
		X_NEG = 3'd3,
		Y_NEG = 3'd4
	} port_dir_e;

	// Routing algorithms the planner can build
	typedef enum logic
	{
		ALGO_XY         = 1'b0,
		ALGO_WEST_FIRST = 1'b1
	} algo_e;

	// Flit kinds, single is head and tail at once
	typedef enum logic [1:0]
	{
		FLIT_BODY   = 2'd0,
		FLIT_HEAD   = 2'd1,
		FLIT_TAIL   = 2'd2,
		FLIT_SINGLE = 2'd3
	} flit_kind_e;

	// Header carried in the low data bits of head and single flits
	typedef struct packed
	{
		logic                  done;
		logic [ADDR_FIELD-1:0] x;
		logic [ADDR_FIELD-1:0] y;
	} header_t;

	typedef struct packed
	{
		flit_kind_e  kind;
		logic [15:0] data;
	} flit_t;

	// Bit of the 4-bit request vector for target, seen from input own
	// The own direction is skipped, the first remaining port is bit 3
	function automatic logic [3:0] port_bit(port_dir_e own, port_dir_e target);
		int pos;
		logic [3:0] vec;
		vec = '0;
		if (target != own)
		begin
			pos = (target > own) ? int'(target) - 1 : int'(target);
			vec[3 - pos] = 1'b1;
		end
		return vec;
	endfunction

endpackage

/* input_fifo.sv */
`timescale 1ns/1ps

module input_fifo import noc_pkg::*;
#(
	parameter int DEPTH = 4
)
(
	input  logic  clk,
	input  logic  rst_n,
	input  flit_t in_flit,
	input  logic  in_valid,
	input  logic  pop,
	output flit_t front,
	output logic  empty,
	output logic  full
);

	localparam int PTR_W = $clog2(DEPTH);

	// Flit storage
	flit_t mem [DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;
	logic [PTR_W:0]   count_next;
	logic             do_write;
	logic             do_read;

	// Writes while full and pops while empty are ignored
	assign do_write = in_valid && !full;
	assign do_read  = pop && !empty;

	always_comb
	begin
		count_next = count;
		if (do_write && !do_read)
			count_next = count + 1'b1;
		else if (!do_write && do_read)
			count_next = count - 1'b1;
	end

	// Pointers wrap on their own since DEPTH is a power of two
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			empty  <= 1'b1;
			full   <= 1'b0;
		end
		else
		begin
			if (do_write)
				wr_ptr <= wr_ptr + 1'b1;
			if (do_read)
				rd_ptr <= rd_ptr + 1'b1;
			count <= count_next;
			// Status levels registered from the next count
			empty <= (count_next == '0);
			full  <= (count_next == (PTR_W+1)'(DEPTH));
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_write)
			mem[wr_ptr] <= in_flit;
	end

	// Oldest flit, visible right after the write edge
	assign front = mem[rd_ptr];

endmodule

/* dor_xy.sv */
`timescale 1ns/1ps

module dor_xy import noc_pkg::*;
#(
	parameter port_dir_e PORT_DIR = X_NEG,
	parameter int        X_LOCAL  = 1,
	parameter int        Y_LOCAL  = 1
)
(
	input  header_t    hdr,
	output logic [3:0] valid_channels
);

	// Local coordinates at header width
	localparam logic [ADDR_FIELD-1:0] X_HERE = ADDR_FIELD'(X_LOCAL);
	localparam logic [ADDR_FIELD-1:0] Y_HERE = ADDR_FIELD'(Y_LOCAL);

	port_dir_e target;

	// X first, then Y, one output only
	always_comb
	begin
		if (hdr.done || (hdr.x == X_HERE && hdr.y == Y_HERE))
			// Leave at this PE
			target = PE;
		else if (hdr.x != X_HERE)
		begin
			if (hdr.x > X_HERE)
				target = X_POS;
			else
				target = X_NEG;
		end
		else if (hdr.y > Y_HERE)
			target = Y_POS;
		else
			target = Y_NEG;
	end

	// Own direction drops out of the vector
	assign valid_channels = port_bit(PORT_DIR, target);

endmodule

/* west_first_minimal.sv */
`timescale 1ns/1ps

module west_first_minimal import noc_pkg::*;
#(
	parameter port_dir_e PORT_DIR = X_NEG,
	parameter int        X_LOCAL  = 1,
	parameter int        Y_LOCAL  = 1
)
(
	input  header_t    hdr,
	output logic [3:0] valid_channels
);

	localparam logic [ADDR_FIELD-1:0] X_HERE = ADDR_FIELD'(X_LOCAL);
	localparam logic [ADDR_FIELD-1:0] Y_HERE = ADDR_FIELD'(Y_LOCAL);

	logic at_home;
	logic go_west;

	assign at_home = hdr.done || (hdr.x == X_HERE && hdr.y == Y_HERE);
	// West turns are not allowed later, so west goes first and alone
	assign go_west = (hdr.x < X_HERE);

	always_comb
	begin
		valid_channels = '0;
		if (at_home)
			valid_channels = port_bit(PORT_DIR, PE);
		else if (go_west)
			valid_channels = port_bit(PORT_DIR, X_NEG);
		else
		begin
			// Every productive direction, one or two bits
			if (hdr.x > X_HERE)
				valid_channels = valid_channels | port_bit(PORT_DIR, X_POS);
			if (hdr.y > Y_HERE)
				valid_channels = valid_channels | port_bit(PORT_DIR, Y_POS);
			if (hdr.y < Y_HERE)
				valid_channels = valid_channels | port_bit(PORT_DIR, Y_NEG);
		end
	end

endmodule

/* route_planner.sv */
`timescale 1ns/1ps

module route_planner import noc_pkg::*;
#(
	parameter port_dir_e PORT_DIR = X_NEG,
	parameter int        X_LOCAL  = 1,
	parameter int        Y_LOCAL  = 1,
	parameter algo_e     ALGO     = ALGO_XY
)
(
	input  header_t    hdr,
	output logic [3:0] request_vector
);

	// Only one routing block is built
	generate
		if (ALGO == ALGO_XY)
		begin : g_xy
			// Deterministic, exactly one request bit
			dor_xy
			#(
				.PORT_DIR (PORT_DIR),
				.X_LOCAL  (X_LOCAL),
				.Y_LOCAL  (Y_LOCAL)
			)
			u_dor_xy
			(
				.hdr            (hdr),
				.valid_channels (request_vector)
			);
		end
		else
		begin : g_west_first
			// Adaptive, the switch picks among the set bits
			west_first_minimal
			#(
				.PORT_DIR (PORT_DIR),
				.X_LOCAL  (X_LOCAL),
				.Y_LOCAL  (Y_LOCAL)
			)
			u_west_first_minimal
			(
				.hdr            (hdr),
				.valid_channels (request_vector)
			);
		end
	endgenerate

endmodule

/* link_controller.sv */
`timescale 1ns/1ps

module link_controller import noc_pkg::*;
(
	input  logic       clk,
	input  logic       rst_n,
	input  flit_t      front,
	input  logic       empty,
	input  logic [3:0] request_vector,
	input  logic [3:0] grant,
	input  logic       stall,
	output header_t    hdr,
	output logic       pop,
	output logic [3:0] request,
	output flit_t      out_flit,
	output logic       out_valid,
	output logic [3:0] out_sel
);

	typedef enum logic [1:0]
	{
		IDLE,
		REQUEST,
		FORWARD
	} state_e;

	state_e state;

	logic       head_ready;
	logic       last_flit;
	logic [3:0] overlap;
	logic [3:0] lowest;

	// Header fields from the front flit go straight to the planner
	assign hdr = header_t'(front.data[$bits(header_t)-1:0]);

	assign head_ready = !empty && (front.kind == FLIT_HEAD || front.kind == FLIT_SINGLE);
	assign last_flit  = (front.kind == FLIT_TAIL || front.kind == FLIT_SINGLE);

	// Granted outputs among those requested, keep the lowest one
	assign overlap = grant & request;
	assign lowest  = overlap & (~overlap + 4'd1);

	// Pop only while forwarding and the switch accepts
	assign pop = (state == FORWARD) && !empty && !stall;

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state     <= IDLE;
			request   <= '0;
			out_sel   <= '0;
			out_valid <= 1'b0;
		end
		else
		begin
			out_valid <= pop;
			case (state)
				IDLE:
				begin
					// Latch the route of a new packet
					if (head_ready)
					begin
						request <= request_vector;
						state   <= REQUEST;
					end
				end
				REQUEST:
				begin
					if (|overlap)
					begin
						out_sel <= lowest;
						request <= '0;
						state   <= FORWARD;
					end
				end
				FORWARD:
				begin
					// Tail or single ends the packet
					if (pop && last_flit)
						state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
		end
	end

	// Flit shows up one cycle after its pop
	always_ff @(posedge clk)
	begin
		if (pop)
			out_flit <= front;
	end

endmodule

/* input_channel.sv */
`timescale 1ns/1ps

module input_channel import noc_pkg::*;
#(
	parameter port_dir_e PORT_DIR = X_NEG,
	parameter int        X_LOCAL  = 1,
	parameter int        Y_LOCAL  = 1,
	parameter algo_e     ALGO     = ALGO_XY,
	parameter int        DEPTH    = 4
)
(
	input  logic       clk,
	input  logic       rst_n,
	input  flit_t      in_flit,
	input  logic       in_valid,
	output logic       full,
	output logic [3:0] request,
	input  logic [3:0] grant,
	input  logic       stall,
	output flit_t      out_flit,
	output logic       out_valid,
	output logic [3:0] out_sel
);

	flit_t      front;
	logic       empty;
	logic       pop;
	header_t    hdr;
	logic [3:0] request_vector;

	// Buffer for flits from the upstream link
	input_fifo #(.DEPTH (DEPTH)) u_input_fifo
	(
		.clk      (clk),
		.rst_n    (rst_n),
		.in_flit  (in_flit),
		.in_valid (in_valid),
		.pop      (pop),
		.front    (front),
		.empty    (empty),
		.full     (full)
	);

	// Route of the header at the front of the buffer
	route_planner
	#(
		.PORT_DIR (PORT_DIR),
		.X_LOCAL  (X_LOCAL),
		.Y_LOCAL  (Y_LOCAL),
		.ALGO     (ALGO)
	)
	u_route_planner
	(
		.hdr            (hdr),
		.request_vector (request_vector)
	);

	// Switch request, grant wait and forwarding
	link_controller u_link_controller
	(
		.clk            (clk),
		.rst_n          (rst_n),
		.front          (front),
		.empty          (empty),
		.request_vector (request_vector),
		.grant          (grant),
		.stall          (stall),
		.hdr            (hdr),
		.pop            (pop),
		.request        (request),
		.out_flit       (out_flit),
		.out_valid      (out_valid),
		.out_sel        (out_sel)
	);

endmodule

/* input_channel_asserts.sv */
`timescale 1ns/1ps

module input_channel_asserts
(
	input logic       clk,
	input logic       rst_n,
	input logic       pop,
	input logic [3:0] request,
	input logic       out_valid,
	input logic [3:0] out_sel
);

	// Failure tally, summed into the final result by the testbench
	int fail_count = 0;

	// Every delivered flit was popped on the edge before
	a_valid_after_pop : assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $past(pop))
	else
	begin
		$error("out_valid high without a pop in the previous cycle");
		fail_count++;
	end

	// No switch request right after reset
	a_request_after_reset : assert property (@(posedge clk)
		$rose(rst_n) |-> (request == 4'b0000))
	else
	begin
		$error("request not zero after reset");
		fail_count++;
	end

	// One output selected whenever a flit leaves
	a_sel_onehot : assert property (@(posedge clk) disable iff (!rst_n)
		out_valid |-> $onehot(out_sel))
	else
	begin
		$error("out_sel not one-hot while out_valid is high");
		fail_count++;
	end

endmodule

bind input_channel input_channel_asserts u_input_channel_asserts
(
	.clk       (clk),
	.rst_n     (rst_n),
	.pop       (pop),
	.request   (request),
	.out_valid (out_valid),
	.out_sel   (out_sel)
);

/* tb_input_channel.sv */
`timescale 1ns/1ps

module tb_input_channel import noc_pkg::*;
();

	localparam int X_LOC       = 1;
	localparam int Y_LOC       = 1;
	localparam int DEPTH       = 4;
	localparam int NUM_PACKETS = 40;

	logic       clk;
	logic       rst_n;
	flit_t      in_flit;
	logic       in_valid;
	logic [3:0] grant;
	logic       stall;

	// Outputs of the XY instance
	logic       full_xy;
	logic [3:0] request_xy;
	flit_t      out_flit_xy;
	logic       out_valid_xy;
	logic [3:0] out_sel_xy;

	// Outputs of the west-first instance
	logic       full_wf;
	logic [3:0] request_wf;
	flit_t      out_flit_wf;
	logic       out_valid_wf;
	logic [3:0] out_sel_wf;

	logic [31:0] lcg_state = 32'd67;
	int          checks    = 0;
	int          errors    = 0;

	// Flits still owed by each instance, oldest first
	flit_t exp_xy [$];
	flit_t exp_wf [$];

	input_channel #(.PORT_DIR (X_NEG), .X_LOCAL (X_LOC), .Y_LOCAL (Y_LOC), .ALGO (ALGO_XY),
		.DEPTH (DEPTH)) u_input_channel
	(
		.clk (clk), .rst_n (rst_n), .in_flit (in_flit), .in_valid (in_valid),
		.full (full_xy), .request (request_xy), .grant (grant), .stall (stall),
		.out_flit (out_flit_xy), .out_valid (out_valid_xy), .out_sel (out_sel_xy)
	);

	input_channel #(.PORT_DIR (X_NEG), .X_LOCAL (X_LOC), .Y_LOCAL (Y_LOC),
		.ALGO (ALGO_WEST_FIRST), .DEPTH (DEPTH)) u_input_channel_wf
	(
		.clk (clk), .rst_n (rst_n), .in_flit (in_flit), .in_valid (in_valid),
		.full (full_wf), .request (request_wf), .grant (grant), .stall (stall),
		.out_flit (out_flit_wf), .out_valid (out_valid_wf), .out_sel (out_sel_wf)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// Upper LCG bits are the better mixed ones
	function automatic int unsigned pick(input int unsigned n);
		return (next_random() >> 16) % n;
	endfunction

	// From the X_NEG input the bits are PE, X_POS, Y_POS, Y_NEG
	function automatic logic [3:0] xy_route(input header_t h);
		if (h.done || (h.x == X_LOC && h.y == Y_LOC))
			return 4'b1000;
		if (h.x > X_LOC)
			return 4'b0100;
		if (h.x < X_LOC)
			return 4'b0000;
		if (h.y > Y_LOC)
			return 4'b0010;
		return 4'b0001;
	endfunction

	function automatic logic [3:0] wf_route(input header_t h);
		logic [3:0] v;
		v = 4'b0000;
		if (h.done || (h.x == X_LOC && h.y == Y_LOC))
			return 4'b1000;
		if (h.x < X_LOC)
			return 4'b0000;
		// All productive directions east, north and south
		if (h.x > X_LOC)
			v[2] = 1'b1;
		if (h.y > Y_LOC)
			v[1] = 1'b1;
		if (h.y < Y_LOC)
			v[0] = 1'b1;
		return v;
	endfunction

	function automatic logic [3:0] lowest_bit(input logic [3:0] v);
		for (int i = 0; i < 4; i++)
			if (v[i])
				return 4'b0001 << i;
		return 4'b0000;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checks++;
		if (expected !== actual)
		begin
			errors++;
			$display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
		end
	endtask

	// Watchdog, 40 cycles per packet plus reset
	initial
	begin
		repeat (16 + NUM_PACKETS * 40) @(posedge clk);
		$display("Timeout: the run did not finish in %0d cycles", 16 + NUM_PACKETS * 40);
		$display("ERRORS FOUND");
		$finish;
	end

	initial
	begin
		header_t    hdr;
		flit_t      f;
		int         len;
		logic       stall_test;
		logic       seen;
		logic [3:0] req_xy;
		logic [3:0] req_wf;
		logic [3:0] g;
		logic [3:0] sel_xy;
		logic [3:0] sel_wf;
		int         err_start;
		int         afail;
		string      tag;

		rst_n    = 1'b0;
		in_flit  = '0;
		in_valid = 1'b0;
		grant    = 4'b0000;
		stall    = 1'b0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		for (int n = 0; n < NUM_PACKETS; n++)
		begin
			err_start  = errors;
			tag        = $sformatf("pkt%0d", n);
			stall_test = (pick(4) == 0);
			// Stalled packets fill the FIFO exactly
			len        = stall_test ? DEPTH : 1 + pick(4);
			hdr.done   = (pick(6) == 0);
			hdr.x      = (pick(3) == 0) ? ADDR_FIELD'(X_LOC) : ADDR_FIELD'(1 + pick(15));
			hdr.y      = ADDR_FIELD'(pick(16));

			for (int i = 0; i < len; i++)
			begin
				f.data = 16'(next_random() >> 8);
				if (len == 1)
					f.kind = FLIT_SINGLE;
				else if (i == 0)
					f.kind = FLIT_HEAD;
				else if (i == len - 1)
					f.kind = FLIT_TAIL;
				else
					f.kind = FLIT_BODY;
				if (i == 0)
					f.data[$bits(header_t)-1:0] = hdr;
				exp_xy.push_back(f);
				exp_wf.push_back(f);
				@(posedge clk);
				stall    <= stall_test;
				in_flit  <= f;
				in_valid <= 1'b1;
			end
			@(posedge clk);
			in_valid <= 1'b0;

			// Both instances raise a request for the head
			seen = 1'b0;
			for (int c = 0; c < 12 && !seen; c++)
			begin
				@(negedge clk);
				seen = (request_xy != 4'b0000) && (request_wf != 4'b0000);
			end
			if (!seen)
			begin
				errors++;
				$display("%s: request did not rise on both instances", tag);
			end

			req_xy = xy_route(hdr);
			req_wf = wf_route(hdr);
			check({tag, " xy request"}, req_xy, request_xy);
			check({tag, " xy request bits"}, 1, $countones(request_xy));
			check({tag, " wf request"}, req_wf, request_wf);
			if (!hdr.done && hdr.x != X_LOC && hdr.y != Y_LOC)
				check({tag, " wf request bits"}, 2, $countones(request_wf));
			if (hdr.done)
			begin
				check({tag, " done xy"}, 4'b1000, request_xy);
				check({tag, " done wf"}, 4'b1000, request_wf);
			end

			// Random grant, widened so both instances find an overlap
			g = 4'(pick(16));
			if ((g & req_xy) == 4'b0000 || (g & req_wf) == 4'b0000)
				g = g | req_xy | req_wf;
			sel_xy = lowest_bit(g & req_xy);
			sel_wf = lowest_bit(g & req_wf);
			@(posedge clk);
			grant <= g;

			if (stall_test)
			begin
				repeat (6)
				begin
					@(negedge clk);
					check({tag, " out_valid in stall"}, 0, out_valid_xy | out_valid_wf);
				end
				check({tag, " full xy"}, 1, full_xy);
				check({tag, " full wf"}, 1, full_wf);
				@(posedge clk);
				stall <= 1'b0;
			end

			for (int c = 0; c < 40 && (exp_xy.size() > 0 || exp_wf.size() > 0); c++)
			begin
				@(negedge clk);
				if (out_valid_xy && exp_xy.size() > 0)
				begin
					check({tag, " xy flit"}, exp_xy.pop_front(), out_flit_xy);
					check({tag, " xy out_sel"}, sel_xy, out_sel_xy);
				end
				else if (out_valid_xy)
				begin
					errors++;
					$display("%s: xy instance delivered a flit that was never sent", tag);
				end
				if (out_valid_wf && exp_wf.size() > 0)
				begin
					check({tag, " wf flit"}, exp_wf.pop_front(), out_flit_wf);
					check({tag, " wf out_sel"}, sel_wf, out_sel_wf);
				end
				else if (out_valid_wf)
				begin
					errors++;
					$display("%s: wf instance delivered a flit that was never sent", tag);
				end
			end
			if (exp_xy.size() > 0 || exp_wf.size() > 0)
			begin
				errors++;
				$display("%s: flits missing at the output", tag);
			end
			exp_xy.delete();
			exp_wf.delete();
			@(posedge clk);
			grant <= 4'b0000;

			$display("%s: len %0d stall %0b %s", tag, len, stall_test,
				(errors == err_start) ? "passed" : "failed");
		end

		afail = u_input_channel.u_input_channel_asserts.fail_count +
			u_input_channel_wf.u_input_channel_asserts.fail_count;
		$display("%0d checks, %0d errors, %0d assertion failures", checks, errors, afail);
		if (errors == 0 && afail == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* list.f */
noc_pkg.sv
input_fifo.sv
dor_xy.sv
west_first_minimal.sv
route_planner.sv
link_controller.sv
input_channel.sv
input_channel_asserts.sv
tb_input_channel.sv
